//--- hdl/core_pkg.sv
package core_pkg;

    // ========================================================================
    // Architectural widths
    // ========================================================================

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] pc_t;
    typedef logic [31:0]     inst_t;
    typedef logic [6:0]      opcode_t;

    // RV32I major opcodes seen by the front end
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    function automatic opcode_t opcode_of(input inst_t inst);
        return inst[6:0];
    endfunction

    // Immediate in the format implied by the opcode, I-type for everything else
    function automatic word_t imm_decode(input inst_t inst);
        word_t imm;
        case (opcode_of(inst))
            OPC_STORE:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OPC_BRANCH:
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {inst[31:12], 12'b0};
            OPC_JAL:
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = {{20{inst[31]}}, inst[31:20]};
        endcase
        return imm;
    endfunction

endpackage

//--- hdl/frontend_pkg.sv
package frontend_pkg;

    // ========================================================================
    // Front-end geometry
    // ========================================================================

    localparam int FETCH_WIDTH  = 3;
    localparam int BUFFER_DEPTH = 16;
    localparam int BP_ENTRIES   = 64;

    typedef logic [$clog2(BUFFER_DEPTH)-1:0] buf_ptr_t;
    typedef logic [$clog2(BUFFER_DEPTH):0]   buf_count_t;
    typedef logic [$clog2(BP_ENTRIES)-1:0]   bp_index_t;

    // Two-bit saturating counter, upper bit is the taken prediction
    typedef logic [1:0] bp_counter_t;
    localparam bp_counter_t BP_INIT = 2'b01;

    // Word-aligned PC bits select the counter
    function automatic bp_index_t bp_index_of(input core_pkg::pc_t pc);
        return pc[$clog2(BP_ENTRIES)+1:2];
    endfunction

    // ========================================================================
    // Stage payloads
    // ========================================================================

    typedef struct packed {
        core_pkg::pc_t   pc;
        core_pkg::inst_t inst;
        logic            pred_taken;
    } fetch_slot_t;

    typedef struct packed {
        fetch_slot_t [FETCH_WIDTH-1:0] slot;
        logic        [FETCH_WIDTH-1:0] valid;
    } fetch_group_t;

    typedef struct packed {
        fetch_slot_t     fetch;
        core_pkg::word_t imm;
    } decoded_slot_t;

    typedef struct packed {
        decoded_slot_t [FETCH_WIDTH-1:0] slot;
        logic          [FETCH_WIDTH-1:0] valid;
    } issue_group_t;

    // One resolved branch from the back end
    typedef struct packed {
        logic          valid;
        logic          is_branch;
        logic          taken;
        logic          mispredict;
        core_pkg::pc_t pc;
        core_pkg::pc_t target;
    } redirect_t;

endpackage

//--- hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,
    input  frontend_pkg::bp_index_t [frontend_pkg::FETCH_WIDTH-1:0] rd_index_i,
    output logic                    [frontend_pkg::FETCH_WIDTH-1:0] rd_taken_o,
    input  frontend_pkg::redirect_t                              update_i
);

    frontend_pkg::bp_counter_t counter_q [frontend_pkg::BP_ENTRIES];
    frontend_pkg::bp_index_t   upd_index;
    frontend_pkg::bp_counter_t upd_old;
    frontend_pkg::bp_counter_t upd_new;
    logic                      upd_en;

    // Only conditional branches train the table
    assign upd_en    = update_i.valid && update_i.is_branch;
    assign upd_index = frontend_pkg::bp_index_of(update_i.pc);
    assign upd_old   = counter_q[upd_index];

    always_comb begin
        upd_new = upd_old;
        if (update_i.taken) begin
            if (upd_old != 2'b11) begin
                upd_new = upd_old + 2'b01;
            end
        end else begin
            if (upd_old != 2'b00) begin
                upd_new = upd_old - 2'b01;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < frontend_pkg::BP_ENTRIES; i++) begin
                counter_q[i] <= frontend_pkg::BP_INIT;
            end
        end else if (upd_en) begin
            counter_q[upd_index] <= upd_new;
        end
    end

    // Three independent lookups, one per fetch slot
    always_comb begin
        for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
            rd_taken_o[i] = counter_q[rd_index_i[i]][1];
        end
    end

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,
    output core_pkg::pc_t           [frontend_pkg::FETCH_WIDTH-1:0] inst_addr_o,
    input  core_pkg::inst_t         [frontend_pkg::FETCH_WIDTH-1:0] inst_data_i,
    output frontend_pkg::bp_index_t [frontend_pkg::FETCH_WIDTH-1:0] bp_index_o,
    input  logic                    [frontend_pkg::FETCH_WIDTH-1:0] bp_taken_i,
    input  frontend_pkg::redirect_t                              redirect_i,
    input  frontend_pkg::buf_count_t                             buf_free_i,
    output logic                                                 push_o,
    output frontend_pkg::fetch_group_t                           push_group_o,
    output logic                                                 flush_o
);

    core_pkg::pc_t                                    pc_q;
    core_pkg::pc_t                                    pc_next;
    core_pkg::opcode_t [frontend_pkg::FETCH_WIDTH-1:0] slot_opc;
    core_pkg::pc_t     [frontend_pkg::FETCH_WIDTH-1:0] slot_target;
    logic              [frontend_pkg::FETCH_WIDTH-1:0] slot_taken;
    logic              [frontend_pkg::FETCH_WIDTH-1:0] slot_valid;
    logic                                             cut_seen;
    logic                                             room;
    logic                                             mispredict;

    // ========================================================================
    // Group addresses and per-slot prediction
    // ========================================================================

    always_comb begin
        for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
            inst_addr_o[i] = pc_q + core_pkg::pc_t'(4 * i);
            bp_index_o[i]  = frontend_pkg::bp_index_of(pc_q + core_pkg::pc_t'(4 * i));
        end
    end

    // JAL always taken, conditional branches follow the counter
    always_comb begin
        for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
            slot_opc[i]    = core_pkg::opcode_of(inst_data_i[i]);
            slot_taken[i]  = (slot_opc[i] == core_pkg::OPC_JAL) ||
                             ((slot_opc[i] == core_pkg::OPC_BRANCH) && bp_taken_i[i]);
            slot_target[i] = inst_addr_o[i] + core_pkg::imm_decode(inst_data_i[i]);
        end
    end

    // First taken slot ends the group and supplies the next PC
    always_comb begin
        slot_valid = '0;
        cut_seen   = 1'b0;
        pc_next    = pc_q + core_pkg::pc_t'(4 * frontend_pkg::FETCH_WIDTH);
        for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
            if (!cut_seen) begin
                slot_valid[i] = 1'b1;
                if (slot_taken[i]) begin
                    cut_seen = 1'b1;
                    pc_next  = slot_target[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
            push_group_o.slot[i].pc         = inst_addr_o[i];
            push_group_o.slot[i].inst       = inst_data_i[i];
            push_group_o.slot[i].pred_taken = slot_taken[i] && slot_valid[i];
        end
        push_group_o.valid = slot_valid;
    end

    // ========================================================================
    // Push, flush and PC update
    // ========================================================================

    assign mispredict = redirect_i.valid && redirect_i.mispredict;
    assign room       = buf_free_i >= frontend_pkg::buf_count_t'(frontend_pkg::FETCH_WIDTH);
    assign push_o     = room && !mispredict;
    assign flush_o    = mispredict;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= '0;
        end else if (mispredict) begin
            pc_q <= redirect_i.target;
        end else if (push_o) begin
            pc_q <= pc_next;
        end
    end

endmodule

//--- hdl/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  frontend_pkg::fetch_group_t push_group_i,
    output frontend_pkg::buf_count_t   free_o,
    output frontend_pkg::fetch_group_t pop_group_o,
    input  logic [1:0]                 pop_count_i
);

    frontend_pkg::fetch_slot_t mem_q [frontend_pkg::BUFFER_DEPTH];

    frontend_pkg::buf_ptr_t                                  head_q;
    frontend_pkg::buf_ptr_t                                  tail_q;
    frontend_pkg::buf_count_t                                count_q;
    frontend_pkg::buf_ptr_t [frontend_pkg::FETCH_WIDTH-1:0]  wr_addr;
    logic [1:0]                                              fill;
    logic [1:0]                                              push_n;

    // ========================================================================
    // Write side
    // ========================================================================

    // Valid slots land back to back starting at the tail
    always_comb begin
        fill = 2'd0;
        for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
            wr_addr[i] = tail_q + frontend_pkg::buf_ptr_t'(fill);
            if (push_group_i.valid[i]) begin
                fill = fill + 2'd1;
            end
        end
    end

    assign push_n = push_i ? fill : 2'd0;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
                if (push_group_i.valid[i]) begin
                    mem_q[wr_addr[i]] <= push_group_i.slot[i];
                end
            end
        end
    end

    // ========================================================================
    // Read side
    // ========================================================================

    // Oldest entries first, valid mask follows occupancy
    always_comb begin
        for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
            pop_group_o.slot[i]  = mem_q[head_q + frontend_pkg::buf_ptr_t'(i)];
            pop_group_o.valid[i] = count_q > frontend_pkg::buf_count_t'(i);
        end
    end

    assign free_o = frontend_pkg::buf_count_t'(frontend_pkg::BUFFER_DEPTH) - count_q;

    // ========================================================================
    // Pointers and occupancy
    // ========================================================================

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + frontend_pkg::buf_ptr_t'(pop_count_i);
            tail_q  <= tail_q + frontend_pkg::buf_ptr_t'(push_n);
            count_q <= count_q + frontend_pkg::buf_count_t'(push_n)
                       - frontend_pkg::buf_count_t'(pop_count_i);
        end
    end

endmodule

//--- hdl/predecode_unit.sv
`timescale 1ns/1ps

module predecode_unit (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       flush_i,
    input  frontend_pkg::fetch_group_t pop_group_i,
    output logic [1:0]                 pop_count_o,
    output frontend_pkg::issue_group_t issue_o,
    input  logic                       issue_ready_i
);

    frontend_pkg::decoded_slot_t [frontend_pkg::FETCH_WIDTH-1:0] slot_q;
    logic                        [frontend_pkg::FETCH_WIDTH-1:0] valid_q;
    logic                                                        load;

    // Take a new group when empty or when the issue side drains this one
    assign load = (!(|valid_q) || issue_ready_i) && !flush_i;

    // Buffer mask is a prefix so the popcount is also the pop depth
    assign pop_count_o = load ? 2'($countones(pop_group_i.valid)) : 2'd0;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            valid_q <= '0;
        end else if (load) begin
            valid_q <= pop_group_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
                slot_q[i].fetch <= pop_group_i.slot[i];
                slot_q[i].imm   <= core_pkg::imm_decode(pop_group_i.slot[i].inst);
            end
        end
    end

    assign issue_o.slot  = slot_q;
    assign issue_o.valid = valid_q;

endmodule

//--- hdl/rv32i_frontend_top.sv
`timescale 1ns/1ps

module rv32i_frontend_top (
    input  logic                                         clk_i,
    input  logic                                         reset_i,
    output core_pkg::pc_t   [frontend_pkg::FETCH_WIDTH-1:0] inst_addr_o,
    input  core_pkg::inst_t [frontend_pkg::FETCH_WIDTH-1:0] inst_data_i,
    input  frontend_pkg::redirect_t                      redirect_i,
    output frontend_pkg::issue_group_t                   issue_o,
    input  logic                                         issue_ready_i
);

    frontend_pkg::bp_index_t [frontend_pkg::FETCH_WIDTH-1:0] bp_index;
    logic                    [frontend_pkg::FETCH_WIDTH-1:0] bp_taken;
    frontend_pkg::buf_count_t                                buf_free;
    frontend_pkg::fetch_group_t                              push_group;
    frontend_pkg::fetch_group_t                              pop_group;
    logic                                                    push;
    logic                                                    flush;
    logic [1:0]                                              pop_count;

    // ========================================================================
    // Prediction and fetch
    // ========================================================================

    branch_predictor u_branch_predictor (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rd_index_i (bp_index),
        .rd_taken_o (bp_taken),
        .update_i   (redirect_i)
    );

    fetch_unit u_fetch_unit (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_addr_o  (inst_addr_o),
        .inst_data_i  (inst_data_i),
        .bp_index_o   (bp_index),
        .bp_taken_i   (bp_taken),
        .redirect_i   (redirect_i),
        .buf_free_i   (buf_free),
        .push_o       (push),
        .push_group_o (push_group),
        .flush_o      (flush)
    );

    // ========================================================================
    // Queue and predecode register
    // ========================================================================

    fetch_buffer u_fetch_buffer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush),
        .push_i       (push),
        .push_group_i (push_group),
        .free_o       (buf_free),
        .pop_group_o  (pop_group),
        .pop_count_i  (pop_count)
    );

    predecode_unit u_predecode_unit (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .flush_i       (flush),
        .pop_group_i   (pop_group),
        .pop_count_o   (pop_count),
        .issue_o       (issue_o),
        .issue_ready_i (issue_ready_i)
    );

endmodule

//--- dv/tb_rv32i_frontend.sv
`timescale 1ns/1ps

module tb_rv32i_frontend;

    localparam int MEM_WORDS  = 256;
    localparam int WAIT_LIMIT = 400;

    logic                                            clk;
    logic                                            reset;
    logic                                            issue_ready;
    core_pkg::pc_t   [frontend_pkg::FETCH_WIDTH-1:0] inst_addr;
    core_pkg::inst_t [frontend_pkg::FETCH_WIDTH-1:0] inst_data;
    frontend_pkg::redirect_t                         redirect;
    frontend_pkg::issue_group_t                      issue;

    core_pkg::inst_t           imem [MEM_WORDS];
    frontend_pkg::bp_counter_t bp_model [frontend_pkg::BP_ENTRIES];
    core_pkg::pc_t             got_pc [$];
    core_pkg::inst_t           got_inst [$];
    core_pkg::word_t           got_imm [$];
    logic                      got_taken [$];
    logic [31:0]               rng;

    rv32i_frontend_top u_rv32i_frontend_top (
        .clk_i         (clk),
        .reset_i       (reset),
        .inst_addr_o   (inst_addr),
        .inst_data_i   (inst_data),
        .redirect_i    (redirect),
        .issue_o       (issue),
        .issue_ready_i (issue_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction memory answers in the same cycle, word index wraps
    always_comb begin
        for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
            inst_data[i] = imem[inst_addr[i][9:2]];
        end
    end

    // Slots count as delivered when ready is high at the following edge
    always @(negedge clk) begin
        if (!reset && issue_ready) begin
            for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
                if (issue.valid[i]) begin
                    got_pc.push_back(issue.slot[i].fetch.pc);
                    got_inst.push_back(issue.slot[i].fetch.inst);
                    got_imm.push_back(issue.slot[i].imm);
                    got_taken.push_back(issue.slot[i].fetch.pred_taken);
                end
            end
        end
    end

    // A fetch group is the PC and the next two words
    always @(negedge clk) begin
        if (!reset) begin
            for (int i = 1; i < frontend_pkg::FETCH_WIDTH; i++) begin
                assert (inst_addr[i] == inst_addr[0] + 32'(4 * i))
                    else fail_now($sformatf("[FAIL] %0t: fetch address %0d is %h after %h",
                                            $time, i, inst_addr[i], inst_addr[0]));
            end
        end
    end

    // ========================================================================
    // Encoding and reference model
    // ========================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic core_pkg::inst_t random_inst(input logic [31:0] r);
        case (r[2:0])
            3'd0: return {r[31:12], r[11:7], core_pkg::OPC_LUI};
            3'd1: return {r[31:12], r[11:7], core_pkg::OPC_AUIPC};
            3'd2: return {r[31:25], r[24:20], r[19:15], 3'b010, r[11:7], core_pkg::OPC_STORE};
            default: return {r[31:20], r[19:15], r[14:12], r[11:7], 7'b0010011};
        endcase
    endfunction

    function automatic core_pkg::inst_t encode_jal(input logic [4:0] rd,
                                                   input core_pkg::word_t imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::OPC_JAL};
    endfunction

    function automatic core_pkg::inst_t encode_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                                   input core_pkg::word_t imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], core_pkg::OPC_BRANCH};
    endfunction

    // Immediate assembled bit by bit from the RV32I format tables
    function automatic core_pkg::word_t field_imm(input core_pkg::inst_t inst);
        core_pkg::word_t sign;
        sign = inst[31] ? 32'hFFFF_FFFF : 32'h0;
        case (inst[6:0])
            core_pkg::OPC_STORE:
                return (sign << 12) | (core_pkg::word_t'(inst[31:25]) << 5)
                       | core_pkg::word_t'(inst[11:7]);
            core_pkg::OPC_BRANCH:
                return (sign << 12) | (core_pkg::word_t'(inst[7]) << 11)
                       | (core_pkg::word_t'(inst[30:25]) << 5)
                       | (core_pkg::word_t'(inst[11:8]) << 1);
            core_pkg::OPC_LUI, core_pkg::OPC_AUIPC:
                return inst & 32'hFFFF_F000;
            core_pkg::OPC_JAL:
                return (sign << 20) | (core_pkg::word_t'(inst[19:12]) << 12)
                       | (core_pkg::word_t'(inst[20]) << 11)
                       | (core_pkg::word_t'(inst[30:21]) << 1);
            default:
                return (sign << 12) | core_pkg::word_t'(inst[31:20]);
        endcase
    endfunction

    // JAL always, conditional branches by the model counter
    function automatic logic predicted_taken(input core_pkg::pc_t pc,
                                             input core_pkg::inst_t inst);
        return (inst[6:0] == core_pkg::OPC_JAL) ||
               ((inst[6:0] == core_pkg::OPC_BRANCH) && bp_model[pc[7:2]][1]);
    endfunction

    // Program order as the fetch rules define it
    function automatic core_pkg::pc_t expected_next(input core_pkg::pc_t pc,
                                                    input core_pkg::inst_t inst);
        return predicted_taken(pc, inst) ? pc + field_imm(inst) : pc + 4;
    endfunction

    // ========================================================================
    // Driving and checking
    // ========================================================================

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_collected();
        got_pc.delete();
        got_inst.delete();
        got_imm.delete();
        got_taken.delete();
    endtask

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            rng = xorshift32(rng);
            imem[i] = random_inst(rng);
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        issue_ready = 1'b1;
        redirect = '0;
        for (int i = 0; i < frontend_pkg::BP_ENTRIES; i++) begin
            bp_model[i] = frontend_pkg::BP_INIT;
        end
        step();
        for (int c = 1; c < 8; c++) begin
            @(negedge clk);
            assert (issue.valid == '0)
                else fail_now($sformatf("[FAIL] %0t: issue valid %b in reset", $time, issue.valid));
            assert (inst_addr[0] == 32'h0)
                else fail_now($sformatf("[FAIL] %0t: fetch pc %h in reset", $time, inst_addr[0]));
            step();
        end
        reset = 1'b0;
        @(negedge clk);
        assert (issue.valid == '0)
            else fail_now($sformatf("[FAIL] %0t: issue valid %b after reset", $time, issue.valid));
        step();
        clear_collected();
    endtask

    task automatic wait_collected(input int n);
        int cycles;
        cycles = 0;
        while (got_pc.size() < n) begin
            step();
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now("Timeout: the issue side did not receive enough instructions");
            end
        end
    endtask

    task automatic check_stream(input core_pkg::pc_t start, input int n);
        core_pkg::pc_t   pc;
        core_pkg::inst_t inst;
        wait_collected(n);
        pc = start;
        for (int k = 0; k < n; k++) begin
            inst = imem[pc[9:2]];
            assert (got_pc[k] == pc)
                else fail_now($sformatf("[FAIL] %0t: issued #%0d pc %h, expected %h",
                                        $time, k, got_pc[k], pc));
            assert (got_inst[k] == inst)
                else fail_now($sformatf("[FAIL] %0t: pc %h inst %h, expected %h",
                                        $time, pc, got_inst[k], inst));
            assert (got_imm[k] == field_imm(inst))
                else fail_now($sformatf("[FAIL] %0t: pc %h imm %h, expected %h",
                                        $time, pc, got_imm[k], field_imm(inst)));
            assert (got_taken[k] == predicted_taken(pc, inst))
                else fail_now($sformatf("[FAIL] %0t: pc %h prediction %b, expected %b",
                                        $time, pc, got_taken[k], predicted_taken(pc, inst)));
            pc = expected_next(pc, inst);
        end
    endtask

    // One resolution pulse, the model counter trains like the predictor
    task automatic send_redirect(input logic is_branch, input logic taken, input logic mispredict,
                                 input core_pkg::pc_t pc, input core_pkg::pc_t target);
        redirect.valid      = 1'b1;
        redirect.is_branch  = is_branch;
        redirect.taken      = taken;
        redirect.mispredict = mispredict;
        redirect.pc         = pc;
        redirect.target     = target;
        if (is_branch && taken && bp_model[pc[7:2]] != 2'b11) begin
            bp_model[pc[7:2]] = bp_model[pc[7:2]] + 2'b01;
        end else if (is_branch && !taken && bp_model[pc[7:2]] != 2'b00) begin
            bp_model[pc[7:2]] = bp_model[pc[7:2]] - 2'b01;
        end
        step();
        redirect = '0;
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic test_reset_state();
        fill_memory();
        apply_reset();
        check_stream(32'h0, 6);
    endtask

    task automatic test_straight_line();
        fill_memory();
        apply_reset();
        check_stream(32'h0, 60);
    endtask

    task automatic test_jal_cut();
        fill_memory();
        imem[1] = encode_jal(5'd1, 32'h40);
        apply_reset();
        check_stream(32'h0, 24);
        assert (got_pc[2] == 32'h44)
            else fail_now($sformatf("[FAIL] %0t: pc after JAL %h", $time, got_pc[2]));
    endtask

    task automatic test_branch_training();
        fill_memory();
        imem[8] = encode_bne(5'd1, 5'd2, 32'hFFFF_FFF0);
        apply_reset();
        check_stream(32'h0, 16);
        send_redirect(1'b1, 1'b1, 1'b0, 32'h20, 32'h10);
        send_redirect(1'b1, 1'b1, 1'b0, 32'h20, 32'h10);
        send_redirect(1'b0, 1'b0, 1'b1, 32'h0, 32'h0);
        clear_collected();
        check_stream(32'h0, 20);
        assert (got_pc[9] == 32'h10)
            else fail_now($sformatf("[FAIL] %0t: pc after trained branch %h", $time, got_pc[9]));
    endtask

    task automatic test_backpressure();
        frontend_pkg::issue_group_t held;
        int                         hold;
        fill_memory();
        apply_reset();
        wait_collected(6);
        rng = xorshift32(rng);
        hold = int'(rng[3:0]) + 5;
        issue_ready = 1'b0;
        @(negedge clk);
        held = issue;
        assert (held.valid != '0)
            else fail_now($sformatf("[FAIL] %0t: no group held under back-pressure", $time));
        for (int c = 0; c < hold; c++) begin
            @(negedge clk);
            assert (issue == held)
                else fail_now($sformatf("[FAIL] %0t: issue changed while not ready", $time));
        end
        step();
        issue_ready = 1'b1;
        check_stream(32'h0, 60);
    endtask

    task automatic test_mispredict();
        fill_memory();
        apply_reset();
        wait_collected(10);
        send_redirect(1'b0, 1'b0, 1'b1, 32'h0, 32'h80);
        assert (issue.valid == '0)
            else fail_now($sformatf("[FAIL] %0t: issue valid %b after flush", $time, issue.valid));
        clear_collected();
        check_stream(32'h80, 30);
    endtask

    initial begin
        reset = 1'b1;
        issue_ready = 1'b1;
        redirect = '0;
        rng = 32'h198c;
        test_reset_state();
        test_straight_line();
        test_jal_cut();
        test_branch_training();
        test_backpressure();
        test_mispredict();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- rv32i_frontend.f
hdl/core_pkg.sv
hdl/frontend_pkg.sv
hdl/branch_predictor.sv
hdl/fetch_unit.sv
hdl/fetch_buffer.sv
hdl/predecode_unit.sv
hdl/rv32i_frontend_top.sv
dv/tb_rv32i_frontend.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f rv32i_frontend.f \
    --top-module tb_rv32i_frontend -o Vtb_rv32i_frontend

./obj_dir/Vtb_rv32i_frontend > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
